// ==== Makefile ====
# Verilator build and run for the SCSI DMA control core testbench

VERILATOR ?= verilator
TOP       ?= scsi_sm_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source file or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^test failed$$" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "^test passed$$" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src.f ====
src/scsi_term_pkg.sv
src/scsi_xfer_pkg.sv
src/sm_strobe_if.sv
src/scsi_sm_terms.sv
src/scsi_sm_outputs.sv
src/scsi_xfer_ctrl.sv
src/scsi_sm.sv
verif/scsi_sm_model.sv
verif/scsi_sm_tb.sv

// ==== src/scsi_sm.sv ====
// SCSI DMA control core built from the term plane, strobe decode and transfer registers
module scsi_sm #(
  parameter int ptr_width = scsi_xfer_pkg::ptr_width_default
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cpureq,
  input  logic                     dmadir,
  input  logic                     dreq,
  input  logic                     lbyte,
  output logic                     dack,
  output logic                     incbo,
  output logic                     incni,
  output logic                     incno,
  output logic                     re,
  output logic                     we,
  output logic                     scsi_cs,
  output logic                     set_dsack,
  output logic                     s2f,
  output logic                     f2s,
  output logic                     s2cpu,
  output logic                     cpu2s,
  output scsi_term_pkg::sm_state_t state,
  output logic                     fifo_empty,
  output logic                     fifo_full
);
  import scsi_term_pkg::*;

  // Active-low product terms from the term plane
  logic [term_count-1:0] terms;
  // Offset condition only goes back to the terms, it does not leave the core
  logic                  boeq3;

  sm_strobe_if strobe_bus ();

  scsi_sm_terms terms_inst (
    .cpureq     (cpureq),
    .dmadir     (dmadir),
    .dreq       (dreq),
    .lbyte      (lbyte),
    .boeq3      (boeq3),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .state      (state),
    .terms      (terms)
  );

  scsi_sm_outputs outputs_inst (
    .terms  (terms),
    .strobe (strobe_bus.decode)
  );

  // FIFO depth follows the pointer width set here
  scsi_xfer_ctrl #(
    .ptr_width (ptr_width)
  ) xfer_ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .strobe     (strobe_bus.ctrl),
    .state      (state),
    .boeq3      (boeq3),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .dack       (dack),
    .incbo      (incbo),
    .incni      (incni),
    .incno      (incno),
    .re         (re),
    .we         (we),
    .scsi_cs    (scsi_cs),
    .set_dsack  (set_dsack),
    .s2f        (s2f),
    .f2s        (f2s),
    .s2cpu      (s2cpu),
    .cpu2s      (cpu2s)
  );

endmodule

// ==== src/scsi_sm_outputs.sv ====
// SCSI FSM OR plane decoding the product terms into transfer strobes and the next state
module scsi_sm_outputs (
  input logic [scsi_term_pkg::term_count-1:0] terms,
  sm_strobe_if.decode                         strobe
);

  // Terms as the OR plane sees them
  logic [scsi_term_pkg::term_count-1:0] e;

  // Group flags for the two-level next state bits go high when a term in the group is low
  logic ns1_a;
  logic ns1_b;
  logic ns2_a;
  logic ns2_b;
  logic ns3_a;
  logic ns3_b;
  logic ns4_a;
  logic ns4_b;
  logic cs_a;
  logic cs_b;

  // Term 9 is fed from term 8 here, so term 9 itself has no effect on any output
  assign e = {terms[27:10], terms[8], terms[8:0]};

  // Single group strobes, each a NAND of its active-low terms
  assign strobe.dack = ~&{e[0], e[1], e[7], e[9], e[13], e[16], e[20], e[21]};
  assign strobe.incbo = ~&{e[10], e[11]};
  assign strobe.incni = ~&{e[2], e[4]};
  assign strobe.incno = ~&{e[2], e[3]};
  assign strobe.re = ~&{e[7], e[12], e[17], e[20], e[21], e[25], e[26], e[27]};
  assign strobe.we = ~&{e[8], e[9], e[13], e[16], e[18], e[24]};
  assign strobe.set_dsack = ~&{e[22], e[25]};
  assign strobe.s2f = ~&{e[7], e[10], e[20], e[21]};
  assign strobe.f2s = ~&{e[9], e[11], e[13], e[16]};
  assign strobe.s2cpu = ~&{e[12], e[17], e[19], e[23], e[25], e[26], e[27]};
  assign strobe.cpu2s = ~&{e[8], e[18], e[22], e[24]};

  // Chip select needs an access term from each half of the array
  assign cs_a = ~&{e[8], e[12], e[17], e[18]};
  assign cs_b = ~&{e[22], e[24], e[25], e[26], e[27]};
  assign strobe.scsi_cs = cs_a & cs_b;

  // Upper state bits pair a group from each half in the same way
  assign ns1_a = ~&{e[12], e[13], e[14], e[15], e[16], e[17]};
  assign ns1_b = ~&{e[18], e[22], e[24], e[26], e[27]};
  assign ns2_a = ~&{e[0], e[2], e[7], e[14]};
  assign ns2_b = ~&{e[15], e[18], e[20], e[21], e[22], e[27]};
  assign ns3_a = ~&{e[0], e[1], e[6], e[12], e[14], e[15]};
  assign ns3_b = ~&{e[19], e[20], e[23], e[24], e[25], e[27]};
  assign ns4_a = ~&{e[1], e[5], e[8], e[11], e[13], e[19]};
  assign ns4_b = ~&{e[21], e[22], e[23], e[24], e[26], e[27]};

  // Bit 0 is a plain OR of its terms
  assign strobe.next_state = {
    ns4_a & ns4_b,
    ns3_a & ns3_b,
    ns2_a & ns2_b,
    ns1_a & ns1_b,
    ~&{e[8], e[9], e[17], e[19], e[23], e[25], e[26]}
  };

endmodule

// ==== src/scsi_sm_terms.sv ====
// SCSI FSM term plane that packs state and conditions and forms the active-low product terms
module scsi_sm_terms (
  input  logic                                 cpureq,
  input  logic                                 dmadir,
  input  logic                                 dreq,
  input  logic                                 lbyte,
  input  logic                                 boeq3,
  input  logic                                 fifo_empty,
  input  logic                                 fifo_full,
  input  scsi_term_pkg::sm_state_t             state,
  output logic [scsi_term_pkg::term_count-1:0] terms
);
  import scsi_term_pkg::*;

  sm_in_t in_word;

  // Field order follows the struct, state in the top bits
  assign in_word.f = {state, cpureq, dmadir, dreq, lbyte, boeq3, fifo_empty, fifo_full};

  // A term goes low when the cared bits of the word equal its value word
  always_comb begin
    for (int i = 0; i < term_count; i++) begin
      terms[i] = ((in_word.raw & term_care[i]) != term_value[i]);
    end
  end

  // The register side must only ever load codes that the table reaches
  // Before the first reset the state is still unknown, so skip it then
  always_comb begin
    if (!$isunknown(state)) begin
      assert (state <= state_last)
        else $error("state %0d is outside the term table", state);
    end
  end

endmodule

// ==== src/scsi_term_pkg.sv ====
// SCSI control FSM term package with the input word layout and the product-term table
package scsi_term_pkg;

  // State code held by the state register
  typedef logic [4:0] sm_state_t;

  localparam sm_state_t state_idle = 5'd0;
  // Highest code the table can ever reach (CPU write access)
  localparam sm_state_t state_last = 5'd10;

  localparam int term_count = 28;

  // Field view of the input word, the state sits in the top five bits
  typedef struct packed {
    sm_state_t state;
    logic      cpureq;
    logic      dmadir;
    logic      dreq;
    logic      lbyte;
    logic      boeq3;
    logic      fifo_empty;
    logic      fifo_full;
  } sm_fields_t;

  // Built from the fields, matched as a raw word
  typedef union packed {
    logic [11:0] raw;
    sm_fields_t  f;
  } sm_in_t;

  typedef logic [11:0] term_word_t;

  // Cubes are written as state_cpureq.dmadir.dreq_lbyte.boeq3.empty.full
  // SCSI to memory byte while the FIFO has room
  localparam term_word_t care_s2m = 12'b11111_111_0001;
  localparam term_word_t val_s2m = 12'b00000_001_0000;
  // Memory to SCSI byte while the FIFO holds data
  localparam term_word_t care_m2s = 12'b11111_111_0010;
  localparam term_word_t val_m2s = 12'b00000_011_0000;
  // Last byte landed on offset three with no request pending
  localparam term_word_t care_last = 12'b11111_101_1100;
  localparam term_word_t val_last = 12'b00000_000_1100;
  // CPU access start from idle, dmadir picks the direction
  localparam term_word_t care_cpu_start = 12'b11111_110_0000;
  localparam term_word_t val_rd_start = 12'b00000_100_0000;
  localparam term_word_t val_wr_start = 12'b00000_110_0000;
  // Read acknowledge and hold, states 1 and 3
  localparam term_word_t care_rd_ack = 12'b11101_100_0000;
  localparam term_word_t val_rd_ack = 12'b00001_100_0000;
  // Write acknowledge and hold, states 6 and 10
  localparam term_word_t care_wr_ack = 12'b10011_100_0000;
  localparam term_word_t val_wr_ack = 12'b00010_100_0000;
  // Spare terms ask for full and empty at once, which the pointers never give
  localparam term_word_t care_off = 12'b00000_000_0011;
  localparam term_word_t val_off = 12'b00000_000_0011;

  // Four terms per line, term 0 first
  localparam term_word_t term_care [term_count] = '{
    care_m2s, care_last, care_off, care_m2s,
    care_s2m, care_off, care_off, care_off,
    care_off, care_off, care_s2m, care_m2s,
    care_off, care_off, care_wr_ack, care_cpu_start,
    care_s2m, care_cpu_start, care_cpu_start, care_off,
    care_off, care_off, care_wr_ack, care_off,
    care_cpu_start, care_rd_ack, care_cpu_start, care_off
  };

  localparam term_word_t term_value [term_count] = '{
    val_m2s, val_last, val_off, val_m2s,
    val_s2m, val_off, val_off, val_off,
    val_off, val_off, val_s2m, val_m2s,
    val_off, val_off, val_wr_ack, val_wr_start,
    val_s2m, val_rd_start, val_wr_start, val_off,
    val_off, val_off, val_wr_ack, val_off,
    val_wr_start, val_rd_ack, val_rd_start, val_off
  };

endpackage

// ==== src/scsi_xfer_ctrl.sv ====
// SCSI transfer control holding the state, strobe registers, byte offset and FIFO pointers
module scsi_xfer_ctrl #(
  parameter int ptr_width = scsi_xfer_pkg::ptr_width_default
) (
  input  logic                     clk,
  input  logic                     rst_n,
  sm_strobe_if.ctrl                strobe,
  output scsi_term_pkg::sm_state_t state,
  output logic                     boeq3,
  output logic                     fifo_empty,
  output logic                     fifo_full,
  output logic                     dack,
  output logic                     incbo,
  output logic                     incni,
  output logic                     incno,
  output logic                     re,
  output logic                     we,
  output logic                     scsi_cs,
  output logic                     set_dsack,
  output logic                     s2f,
  output logic                     f2s,
  output logic                     s2cpu,
  output logic                     cpu2s
);
  import scsi_term_pkg::*;
  import scsi_xfer_pkg::*;

  logic [bo_width-1:0] byte_offset;
  // One extra bit tells a full FIFO from an empty one
  logic [ptr_width:0]  fill_ptr;
  logic [ptr_width:0]  drain_ptr;

  // State and strobes move out one cycle after the terms that made them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= state_idle;
      dack      <= 1'b0;
      incbo     <= 1'b0;
      incni     <= 1'b0;
      incno     <= 1'b0;
      re        <= 1'b0;
      we        <= 1'b0;
      scsi_cs   <= 1'b0;
      set_dsack <= 1'b0;
      s2f       <= 1'b0;
      f2s       <= 1'b0;
      s2cpu     <= 1'b0;
      cpu2s     <= 1'b0;
    end else begin
      state     <= strobe.next_state;
      dack      <= strobe.dack;
      incbo     <= strobe.incbo;
      incni     <= strobe.incni;
      incno     <= strobe.incno;
      re        <= strobe.re;
      we        <= strobe.we;
      scsi_cs   <= strobe.scsi_cs;
      set_dsack <= strobe.set_dsack;
      s2f       <= strobe.s2f;
      f2s       <= strobe.f2s;
      s2cpu     <= strobe.s2cpu;
      cpu2s     <= strobe.cpu2s;
    end
  end

  // Counters step on the decoded strobes in the same edge as the registers load
  // A fill into a full FIFO or a drain from an empty one is dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      byte_offset <= '0;
      fill_ptr    <= '0;
      drain_ptr   <= '0;
    end else begin
      if (strobe.incbo) begin
        byte_offset <= byte_offset + 1'b1;
      end
      if (strobe.incni && !fifo_full) begin
        fill_ptr <= fill_ptr + 1'b1;
      end
      if (strobe.incno && !fifo_empty) begin
        drain_ptr <= drain_ptr + 1'b1;
      end
    end
  end

  // Conditions go straight back to the term plane from the registers
  assign boeq3 = (byte_offset == bo_width'(3));
  assign fifo_empty = (fill_ptr == drain_ptr);
  // Full means the fill side has lapped the drain side once
  assign fifo_full = (fill_ptr == {~drain_ptr[ptr_width], drain_ptr[ptr_width-1:0]});

  // The term table must hold off filling once the fed-back full flag is set
  a_no_fill_full: assert property (@(posedge clk) disable iff (!rst_n)
    strobe.incni |-> !fifo_full)
    else $error("fill strobe while the FIFO is full");

  // Likewise no drain once the empty flag is back
  a_no_drain_empty: assert property (@(posedge clk) disable iff (!rst_n)
    strobe.incno |-> !fifo_empty)
    else $error("drain strobe while the FIFO is empty");

  // SCSI chip read and write are never requested in the same cycle
  a_re_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(strobe.re && strobe.we))
    else $error("re and we decoded together");

endmodule

// ==== src/scsi_xfer_pkg.sv ====
// SCSI transfer side package with counter widths and the DMA direction code
package scsi_xfer_pkg;

  // Byte offset within a longword, so four bytes per word
  localparam int bo_width = 2;

  // Default FIFO address width, eight entries deep
  localparam int ptr_width_default = 3;

  // Level of dmadir for a memory to SCSI transfer
  localparam logic dir_to_scsi = 1'b1;

endpackage

// ==== src/sm_strobe_if.sv ====
// Strobe bundle carrying the decoded transfer strobes and next state to the registers
interface sm_strobe_if;
  import scsi_term_pkg::*;

  // All strobes are active high and valid in every cycle
  logic      dack;
  logic      incbo;
  logic      incni;
  logic      incno;
  logic      re;
  logic      we;
  logic      scsi_cs;
  logic      set_dsack;
  logic      s2f;
  logic      f2s;
  logic      s2cpu;
  logic      cpu2s;
  sm_state_t next_state;

  // Term decode side
  modport decode (
    output dack, incbo, incni, incno, re, we, scsi_cs,
    output set_dsack, s2f, f2s, s2cpu, cpu2s, next_state
  );

  // Register side
  modport ctrl (
    input dack, incbo, incni, incno, re, we, scsi_cs,
    input set_dsack, s2f, f2s, s2cpu, cpu2s, next_state
  );

endinterface

// ==== verif/scsi_sm_model.sv ====
// Reference model of the SCSI DMA control core built from the term table and the group decode
module scsi_sm_model #(
  parameter int ptr_width = scsi_xfer_pkg::ptr_width_default
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cpureq,
  input  logic                     dmadir,
  input  logic                     dreq,
  input  logic                     lbyte,
  output scsi_term_pkg::sm_state_t state,
  output logic [11:0]              strobes,
  output logic                     boeq3,
  output logic                     fifo_empty,
  output logic                     fifo_full
);
  timeunit 1ns;
  timeprecision 1ps;
  import scsi_term_pkg::*;
  import scsi_xfer_pkg::*;

  // One bit per term in each group with dack first down to cpu2s
  // Chip select has no single group and is formed from the pair below
  localparam logic [27:0] strobe_mask [11:0] = '{
    28'h0312283, 28'h0000C00, 28'h0000014, 28'h000000C,
    28'hE321080, 28'h1052300, 28'h0000000, 28'h2400000,
    28'h0300480, 28'h0012A00, 28'hE8A1000, 28'h1440100
  };
  localparam logic [27:0] cs_mask_a = 28'h0061100;
  localparam logic [27:0] cs_mask_b = 28'hF400000;
  localparam logic [27:0] ns0_mask = 28'h68A0300;
  // Next state bits 4 down to 1 each need a hit in both of their groups
  localparam logic [27:0] ns_mask_a [4:1] = '{28'h0082922, 28'h000D043, 28'h0004085, 28'h003F000};
  localparam logic [27:0] ns_mask_b [4:1] = '{28'hDE00000, 28'hB980000, 28'h8748000, 28'hD440000};

  logic [27:0]          hit;
  logic [11:0]          next_strobes;
  sm_state_t            next_state;
  logic [bo_width-1:0]  bo;
  logic [ptr_width:0]   fill;
  logic [ptr_width:0]   drain;

  assign boeq3 = (bo == {bo_width{1'b1}});
  assign fifo_empty = (fill == drain);
  // Full when the fill side is one whole FIFO depth ahead
  assign fifo_full = ((fill - drain) == (ptr_width + 1)'(1 << ptr_width));

  always_comb begin
    logic [11:0] word;
    word = {state, cpureq, dmadir, dreq, lbyte, boeq3, fifo_empty, fifo_full};
    for (int i = 0; i < term_count; i++) begin
      hit[i] = ((word & term_care[i]) == term_value[i]);
    end
    // Term 9 follows term 8 in the decode and never counts on its own
    hit[9] = hit[8];
    for (int i = 0; i < 12; i++) begin
      next_strobes[i] = |(hit & strobe_mask[i]);
    end
    next_strobes[5] = (|(hit & cs_mask_a)) && (|(hit & cs_mask_b));
    next_state[0] = |(hit & ns0_mask);
    for (int b = 1; b < 5; b++) begin
      next_state[b] = (|(hit & ns_mask_a[b])) && (|(hit & ns_mask_b[b]));
    end
  end

  // Bits 10, 9 and 8 of the strobe vector are incbo, incni and incno
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= state_idle;
      strobes <= '0;
      bo      <= '0;
      fill    <= '0;
      drain   <= '0;
    end else begin
      state   <= next_state;
      strobes <= next_strobes;
      if (next_strobes[10]) begin
        bo <= bo + 1'b1;
      end
      if (next_strobes[9] && !fifo_full) begin
        fill <= fill + 1'b1;
      end
      if (next_strobes[8] && !fifo_empty) begin
        drain <= drain + 1'b1;
      end
    end
  end

endmodule

// ==== verif/scsi_sm_tb.sv ====
// Testbench for the SCSI DMA control core with a row table, random rows and a cycle model
module scsi_sm_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import scsi_term_pkg::*;
  import scsi_xfer_pkg::*;

  localparam int ptr_width = ptr_width_default;
  localparam int half_period = 50;
  localparam int rand_cycles = 200;
  localparam int margin_cycles = 50;

  typedef struct packed {
    logic       cpureq;
    logic       dmadir;
    logic       dreq;
    logic       lbyte;
    logic [7:0] count;
    sm_state_t  exp_state;
    logic       exp_empty;
    logic       exp_full;
  } row_t;

  // Columns are cpureq, dmadir, dreq, lbyte, cycles, then state, empty and full at row end
  localparam int row_count = 12;
  localparam row_t stim [row_count] = '{
    '{1'b0, 1'b0, 1'b0, 1'b0, 8'd3, 5'd0, 1'b1, 1'b0},
    // SCSI to memory until the eight entries are taken
    '{1'b0, ~dir_to_scsi, 1'b1, 1'b0, 8'd12, 5'd0, 1'b0, 1'b1},
    '{1'b0, 1'b0, 1'b0, 1'b0, 8'd2, 5'd0, 1'b0, 1'b1},
    // Memory to SCSI drains it all again
    '{1'b0, dir_to_scsi, 1'b1, 1'b0, 8'd12, 5'd0, 1'b1, 1'b0},
    '{1'b0, ~dir_to_scsi, 1'b1, 1'b0, 8'd3, 5'd0, 1'b0, 1'b0},
    // Three more bytes bring the offset to three for the last byte term
    '{1'b0, 1'b0, 1'b0, 1'b1, 8'd2, 5'd0, 1'b0, 1'b0},
    // CPU read goes through state 3 and waits in state 1
    '{1'b1, 1'b0, 1'b0, 1'b0, 8'd4, 5'd1, 1'b0, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 8'd2, 5'd0, 1'b0, 1'b0},
    // CPU write goes through state 10 and waits in state 6
    '{1'b1, 1'b1, 1'b0, 1'b0, 8'd4, 5'd6, 1'b0, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 8'd2, 5'd0, 1'b0, 1'b0},
    '{1'b0, dir_to_scsi, 1'b1, 1'b0, 8'd6, 5'd0, 1'b1, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 8'd2, 5'd0, 1'b1, 1'b0}
  };

  logic        clk;
  logic        rst_n;
  logic        cpureq;
  logic        dmadir;
  logic        dreq;
  logic        lbyte;
  logic        dack;
  logic        incbo;
  logic        incni;
  logic        incno;
  logic        re;
  logic        we;
  logic        scsi_cs;
  logic        set_dsack;
  logic        s2f;
  logic        f2s;
  logic        s2cpu;
  logic        cpu2s;
  sm_state_t   state;
  logic        fifo_empty;
  logic        fifo_full;
  logic [11:0] dut_strobes;
  sm_state_t   exp_state;
  logic [11:0] exp_strobes;
  logic        exp_boeq3;
  logic        exp_empty;
  logic        exp_full;
  logic        checking;
  int          errors;
  int          checks;

  string strobe_name [11:0] = '{"dack", "incbo", "incni", "incno", "re", "we",
                                "scsi_cs", "set_dsack", "s2f", "f2s", "s2cpu", "cpu2s"};

  assign dut_strobes = {dack, incbo, incni, incno, re, we,
                        scsi_cs, set_dsack, s2f, f2s, s2cpu, cpu2s};

  scsi_sm #(
    .ptr_width (ptr_width)
  ) scsi_sm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpureq     (cpureq),
    .dmadir     (dmadir),
    .dreq       (dreq),
    .lbyte      (lbyte),
    .dack       (dack),
    .incbo      (incbo),
    .incni      (incni),
    .incno      (incno),
    .re         (re),
    .we         (we),
    .scsi_cs    (scsi_cs),
    .set_dsack  (set_dsack),
    .s2f        (s2f),
    .f2s        (f2s),
    .s2cpu      (s2cpu),
    .cpu2s      (cpu2s),
    .state      (state),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full)
  );

  scsi_sm_model #(
    .ptr_width (ptr_width)
  ) model_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpureq     (cpureq),
    .dmadir     (dmadir),
    .dreq       (dreq),
    .lbyte      (lbyte),
    .state      (exp_state),
    .strobes    (exp_strobes),
    .boeq3      (exp_boeq3),
    .fifo_empty (exp_empty),
    .fifo_full  (exp_full)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s: got %h, expected %h at %0d ns", name, actual, expected, $time);
    end
  endtask

  function automatic int table_cycle_count();
    int total;
    total = 0;
    for (int r = 0; r < row_count; r++) begin
      total += int'(stim[r].count);
    end
    return total;
  endfunction

  // Outputs settle well before the falling edge, so the model is compared there
  always @(negedge clk) begin : cycle_check
    if (checking) begin
      compare_value("state", 32'(state), 32'(exp_state));
      for (int i = 0; i < 12; i++) begin
        compare_value(strobe_name[i], 32'(dut_strobes[i]), 32'(exp_strobes[i]));
      end
      compare_value("fifo_empty", 32'(fifo_empty), 32'(exp_empty));
      compare_value("fifo_full", 32'(fifo_full), 32'(exp_full));
      compare_value("boeq3", 32'(scsi_sm_inst.boeq3), 32'(exp_boeq3));
      compare_value("re_and_we", 32'(re & we), 32'd0);
    end
  end

  initial begin
    logic [31:0] rnd;
    cpureq   = 1'b0;
    dmadir   = 1'b0;
    dreq     = 1'b0;
    lbyte    = 1'b0;
    rst_n    = 1'b0;
    checking = 1'b0;
    errors   = 0;
    checks   = 0;
    rnd = $urandom(32'hfa37_d619);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Registers keep their reset values until the first edge after release
    @(negedge clk);
    compare_value("reset state", 32'(state), 32'(state_idle));
    compare_value("reset strobes", 32'(dut_strobes), 32'd0);
    compare_value("reset fifo_empty", 32'(fifo_empty), 32'd1);
    checking = 1'b1;
    // Each row end is checked after its last input has been clocked in but one
    for (int r = 0; r < row_count; r++) begin
      for (int c = 0; c < int'(stim[r].count); c++) begin
        @(posedge clk);
        cpureq <= stim[r].cpureq;
        dmadir <= stim[r].dmadir;
        dreq   <= stim[r].dreq;
        lbyte  <= stim[r].lbyte;
      end
      @(negedge clk);
      compare_value("row state", 32'(state), 32'(stim[r].exp_state));
      compare_value("row fifo_empty", 32'(fifo_empty), 32'(stim[r].exp_empty));
      compare_value("row fifo_full", 32'(fifo_full), 32'(stim[r].exp_full));
    end
    // CPU requests are kept rarer so DMA runs get some length
    for (int n = 0; n < rand_cycles; n++) begin
      @(posedge clk);
      rnd = $urandom();
      cpureq <= (rnd[5:4] == 2'b00);
      dmadir <= rnd[1];
      dreq   <= rnd[2];
      lbyte  <= rnd[3];
    end
    @(negedge clk);
    checking = 1'b0;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Limit is the full stimulus length plus reset and a margin
  initial begin : watchdog
    int limit;
    limit = table_cycle_count() + rand_cycles + margin_cycles + 4;
    #(limit * 2 * half_period);
    $display("Watchdog expired after %0d cycles, the stimulus never finished", limit);
    $display("test failed");
    $finish;
  end

endmodule
